// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_ucie_buf
RTL_TOP   = ucie_buf_top
FILELIST  = ucie_buf_top.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: csr_sync.sv
`timescale 1ns/1ps

module csr_sync (
   input  logic clk,
   input  logic rst,
   input  logic i_buf_mode,
   input  logic i_ts_enable,
   input  logic i_ts_reset,
   input  logic i_ts_brkpt_en,
   input  logic i_ig_wdata_en,
   input  logic i_ig_wdata_upd,
   input  logic i_eg_rdata_en,
   input  logic i_eg_rdata_upd,
   output logic o_buf_mode,
   output logic o_ts_enable,
   output logic o_ts_reset,
   output logic o_ts_brkpt_en,
   output logic o_ig_shift,
   output logic o_ig_push,
   output logic o_eg_shift,
   output logic o_eg_pop
);

   localparam int N_CTL = 8;
   localparam int N_TGL = 4;

   logic [N_CTL-1:0] ctl_in;
   logic [N_CTL-1:0] meta_q;
   logic [N_CTL-1:0] sync_q;
   logic [N_TGL-1:0] tgl_q;
   logic [N_TGL-1:0] pulse;

   // Loader toggles sit in the upper bits
   assign ctl_in = {i_eg_rdata_upd, i_eg_rdata_en, i_ig_wdata_upd, i_ig_wdata_en,
                    i_ts_brkpt_en, i_ts_reset, i_ts_enable, i_buf_mode};

   // Two-flop synchronizer, plus one stage for edge detect on the toggles
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         meta_q <= '0;
         sync_q <= '0;
         tgl_q  <= '0;
      end else begin
         meta_q <= ctl_in;
         sync_q <= meta_q;
         tgl_q  <= sync_q[N_CTL-1:N_CTL-N_TGL];
      end
   end

   // Either edge of a toggle gives a one-cycle pulse
   assign pulse = sync_q[N_CTL-1:N_CTL-N_TGL] ^ tgl_q;

   assign o_buf_mode    = sync_q[0];
   assign o_ts_enable   = sync_q[1];
   assign o_ts_reset    = sync_q[2];
   assign o_ts_brkpt_en = sync_q[3];
   assign o_ig_shift    = pulse[0];
   assign o_ig_push     = pulse[1];
   assign o_eg_shift    = pulse[2];
   assign o_eg_pop      = pulse[3];

endmodule

// File: eg_capture.sv
`timescale 1ns/1ps

module eg_capture import ucie_buf_pkg::*; #(
   parameter int DEPTH = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             i_shift,
   input  logic             i_pop,
   input  logic             i_clr,
   input  logic [TS_W-1:0]  i_timestamp,
   input  logic [DQ_W-1:0]  i_rx_dq0,
   input  logic [DQ_W-1:0]  i_rx_dq1,
   input  logic [CA_W-1:0]  i_rx_ca,
   input  logic [2:0]       i_rx_vld,
   output logic [CSR_W-1:0] o_rdata,
   output logic             o_empty,
   output logic             o_full,
   output logic             o_overflow,
   output logic             o_read_done
);

   fifo_if eg_f ();

   entry_u cap_entry;
   entry_u rd_loader_q;
   logic   eg_write;
   logic   read_toggle_q;

   // ---------------------------------------------------------------------------
   // Capture side
   // ---------------------------------------------------------------------------

   // Any lane valid stamps the sample
   assign eg_write = |i_rx_vld;

   assign cap_entry.fields = '{ts:  i_timestamp,
                               dq0: i_rx_dq0,
                               dq1: i_rx_dq1,
                               ca:  i_rx_ca};

   assign eg_f.write = eg_write;
   assign eg_f.wdata = cap_entry;
   assign eg_f.clr   = i_clr;
   assign eg_f.read  = i_pop;

   entry_fifo #(
      .DEPTH (DEPTH)
   ) u_fifo (
      .clk   (clk),
      .rst   (rst),
      .f     (eg_f)
   );

   // ---------------------------------------------------------------------------
   // Readout loader
   // ---------------------------------------------------------------------------

   // Pop loads the head, shift moves the next word down
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_loader_q <= '0;
      end else if (i_pop) begin
         rd_loader_q <= eg_f.rdata;
      end else if (i_shift) begin
         rd_loader_q.words <= {{CSR_W{1'b0}}, rd_loader_q.words[ENTRY_WORDS-1:1]};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         read_toggle_q <= 1'b0;
      end else begin
         read_toggle_q <= read_toggle_q ^ i_pop;
      end
   end

   assign o_rdata     = rd_loader_q.words[0];
   assign o_empty     = ~eg_f.empty_n;
   assign o_full      = eg_f.full;
   assign o_overflow  = eg_f.full & eg_write;
   assign o_read_done = read_toggle_q;

endmodule

// File: entry_fifo.sv
`timescale 1ns/1ps

module entry_fifo import ucie_buf_pkg::*; #(
   parameter int DEPTH = 32
) (
   input  logic clk,
   input  logic rst,
   fifo_if.mem  f
);

   localparam int AW = $clog2(DEPTH);

   entry_u        mem_q [DEPTH];
   logic [AW:0]   wr_ptr_q;
   logic [AW:0]   rd_ptr_q;
   logic          do_write;
   logic          do_read;

   // Extra pointer bit tells full from empty
   assign f.empty_n = (wr_ptr_q != rd_ptr_q);
   assign f.full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                      (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

   // Writes into a full FIFO and reads from an empty one are dropped
   assign do_write = f.write && !f.full;
   assign do_read  = f.read && f.empty_n;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else if (f.clr) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Entry storage
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem_q[wr_ptr_q[AW-1:0]] <= f.wdata;
      end
   end

   // Show-ahead head
   assign f.rdata = mem_q[rd_ptr_q[AW-1:0]];

endmodule

// File: fifo_if.sv
`timescale 1ns/1ps

interface fifo_if import ucie_buf_pkg::*; ();

   // Write side
   logic   write;
   entry_u wdata;
   logic   full;

   // Read side, rdata shows the head entry
   logic   read;
   entry_u rdata;
   logic   empty_n;

   // Empties the FIFO in one cycle
   logic   clr;

   modport ctrl (
      output write, wdata, read, clr,
      input  full, rdata, empty_n
   );

   modport mem (
      input  write, wdata, read, clr,
      output full, rdata, empty_n
   );

endinterface

// File: ig_player.sv
`timescale 1ns/1ps

module ig_player import ucie_buf_pkg::*; #(
   parameter int DEPTH = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             i_buf_mode,
   input  logic             i_shift,
   input  logic             i_push,
   input  logic             i_clr,
   input  logic             i_hold,
   input  logic [CSR_W-1:0] i_wdata,
   input  logic [TS_W-1:0]  i_timestamp,
   input  logic [DQ_W-1:0]  i_tx_dq0,
   input  logic [DQ_W-1:0]  i_tx_dq1,
   input  logic [CA_W-1:0]  i_tx_ca,
   output logic             o_empty,
   output logic             o_full,
   output logic             o_overflow,
   output logic             o_write_done,
   output logic [DQ_W-1:0]  o_tx_dq0,
   output logic [DQ_W-1:0]  o_tx_dq1,
   output logic [CA_W-1:0]  o_tx_ca
);

   fifo_if ig_f ();

   entry_u          loader_q;
   entry_fields_t   head;
   logic            ig_pop;
   logic            empty_q;
   logic            write_toggle_q;
   logic [DQ_W-1:0] hold_dq0_q;
   logic [DQ_W-1:0] hold_dq1_q;
   logic [CA_W-1:0] hold_ca_q;
   logic [DQ_W-1:0] mux_dq0;
   logic [DQ_W-1:0] mux_dq1;
   logic [CA_W-1:0] mux_ca;

   // ---------------------------------------------------------------------------
   // Word loader and FIFO
   // ---------------------------------------------------------------------------

   // First word shifted in ends up in word 2
   always_ff @(posedge clk) begin
      if (i_shift) begin
         loader_q.words <= {loader_q.words[ENTRY_WORDS-2:0], i_wdata};
      end
   end

   assign ig_f.write = i_push;
   assign ig_f.wdata = loader_q;
   assign ig_f.clr   = i_clr;
   assign ig_f.read  = ig_pop;

   entry_fifo #(
      .DEPTH (DEPTH)
   ) u_fifo (
      .clk   (clk),
      .rst   (rst),
      .f     (ig_f)
   );

   // ---------------------------------------------------------------------------
   // Playback on timestamp match
   // ---------------------------------------------------------------------------
   assign head   = ig_f.rdata.fields;
   assign ig_pop = ig_f.empty_n && (head.ts == i_timestamp);

   // Lanes masked to zero between entries unless hold
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         hold_dq0_q <= '0;
         hold_dq1_q <= '0;
         hold_ca_q  <= '0;
      end else if (ig_pop) begin
         hold_dq0_q <= head.dq0;
         hold_dq1_q <= head.dq1;
         hold_ca_q  <= head.ca;
      end else if (!i_hold) begin
         hold_dq0_q <= '0;
         hold_dq1_q <= '0;
         hold_ca_q  <= '0;
      end
   end

   // Mode mux, buffer data or live traffic
   assign mux_dq0 = i_buf_mode ? hold_dq0_q : i_tx_dq0;
   assign mux_dq1 = i_buf_mode ? hold_dq1_q : i_tx_dq1;
   assign mux_ca  = i_buf_mode ? hold_ca_q  : i_tx_ca;

   // Output register toward the PHY
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         o_tx_dq0 <= '0;
         o_tx_dq1 <= '0;
         o_tx_ca  <= '0;
      end else begin
         o_tx_dq0 <= mux_dq0;
         o_tx_dq1 <= mux_dq1;
         o_tx_ca  <= mux_ca;
      end
   end

   // Status
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         empty_q        <= 1'b1;
         write_toggle_q <= 1'b0;
      end else begin
         empty_q        <= ~ig_f.empty_n;
         write_toggle_q <= write_toggle_q ^ i_push;
      end
   end

   assign o_empty      = empty_q;
   assign o_full       = ig_f.full;
   assign o_overflow   = ig_f.full & i_push;
   assign o_write_done = write_toggle_q;

endmodule

// File: tb_ucie_buf.sv
`timescale 1ns/1ps

module tb_ucie_buf;

   localparam int DEPTH        = 8;
   localparam int TGL_GAP      = 8;
   localparam int DONE_TIMEOUT = 12;
   // Run budget from the CSR toggles, two breakpoint waits and a margin
   localparam int N_TOGGLES    = 37;
   localparam int TOGGLE_CYC   = DONE_TIMEOUT + 6;
   localparam int BRKPT_CYC    = 2 * (40 + 12);
   localparam int WATCHDOG_CYC = N_TOGGLES * TOGGLE_CYC + BRKPT_CYC + 300;

   logic        clk;
   logic        rst;
   logic        i_buf_mode;
   logic        i_ts_enable;
   logic        i_ts_reset;
   logic        i_ts_brkpt_en;
   logic [15:0] i_ts_brkpt_val;
   logic        i_ig_wdata_clr;
   logic        i_ig_wdata_hold;
   logic        i_ig_wdata_en;
   logic        i_ig_wdata_upd;
   logic [31:0] i_ig_wdata;
   logic        i_eg_rdata_clr;
   logic        i_eg_rdata_en;
   logic        i_eg_rdata_upd;
   logic [31:0] i_tx_dq0;
   logic [31:0] i_tx_dq1;
   logic [15:0] i_tx_ca;
   logic [31:0] i_rx_dq0;
   logic [31:0] i_rx_dq1;
   logic [15:0] i_rx_ca;
   logic [2:0]  i_rx_vld;
   logic        o_ig_empty;
   logic        o_ig_full;
   logic        o_ig_overflow;
   logic        o_ig_write_done;
   logic [31:0] o_eg_rdata;
   logic        o_eg_empty;
   logic        o_eg_full;
   logic        o_eg_overflow;
   logic        o_eg_read_done;
   logic [31:0] o_tx_dq0;
   logic [31:0] o_tx_dq1;
   logic [15:0] o_tx_ca;

   int          seed;
   int          errors;
   int          checks;
   int          pushes;
   int          pops;
   int          err0;
   logic [15:0] bval;
   logic [31:0] r;
   logic [31:0] dq0_v [4];
   logic [31:0] dq1_v [4];
   logic [15:0] ca_v [4];
   logic [79:0] live_cur;
   logic [79:0] live_prev;
   logic [79:0] exp_q [$];
   logic        ovf;
   logic        load_done;

   ucie_buf_top #(
      .DEPTH (DEPTH)
   ) DUT (
      .clk             (clk),
      .rst             (rst),
      .i_buf_mode      (i_buf_mode),
      .i_ts_enable     (i_ts_enable),
      .i_ts_reset      (i_ts_reset),
      .i_ts_brkpt_en   (i_ts_brkpt_en),
      .i_ts_brkpt_val  (i_ts_brkpt_val),
      .i_ig_wdata_clr  (i_ig_wdata_clr),
      .i_ig_wdata_hold (i_ig_wdata_hold),
      .i_ig_wdata_en   (i_ig_wdata_en),
      .i_ig_wdata_upd  (i_ig_wdata_upd),
      .i_ig_wdata      (i_ig_wdata),
      .i_eg_rdata_clr  (i_eg_rdata_clr),
      .i_eg_rdata_en   (i_eg_rdata_en),
      .i_eg_rdata_upd  (i_eg_rdata_upd),
      .i_tx_dq0        (i_tx_dq0),
      .i_tx_dq1        (i_tx_dq1),
      .i_tx_ca         (i_tx_ca),
      .i_rx_dq0        (i_rx_dq0),
      .i_rx_dq1        (i_rx_dq1),
      .i_rx_ca         (i_rx_ca),
      .i_rx_vld        (i_rx_vld),
      .o_ig_empty      (o_ig_empty),
      .o_ig_full       (o_ig_full),
      .o_ig_overflow   (o_ig_overflow),
      .o_ig_write_done (o_ig_write_done),
      .o_eg_rdata      (o_eg_rdata),
      .o_eg_empty      (o_eg_empty),
      .o_eg_full       (o_eg_full),
      .o_eg_overflow   (o_eg_overflow),
      .o_eg_read_done  (o_eg_read_done),
      .o_tx_dq0        (o_tx_dq0),
      .o_tx_dq1        (o_tx_dq1),
      .o_tx_ca         (o_tx_ca)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("Watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYC);
      $display("TEST FAIL");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Reference model and helpers
   // ------------------------------------------------------------------------

   // Entry as three CSR words with ts and the top of dq0 in word 2
   function automatic logic [95:0] ref_entry(input logic [15:0] ts, input logic [31:0] dq0,
                                             input logic [31:0] dq1, input logic [15:0] ca);
      return {ts, dq0, dq1, ca};
   endfunction

   task automatic check_val(input string name, input logic [31:0] act,
                            input logic [31:0] want);
      checks++;
      if (act !== want) begin
         errors++;
         $display("ERROR at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, act, want);
      end
   endtask

   task automatic settle(input int n);
      repeat (n) @(posedge clk);
      @(negedge clk);
   endtask

   task automatic end_test(input string name, input int err_start);
      $display("%-28s %s", name, (errors == err_start) ? "passed" : "FAILED");
   endtask

   task automatic shift_word(input logic [31:0] w);
      @(posedge clk);
      i_ig_wdata    <= w;
      i_ig_wdata_en <= ~i_ig_wdata_en;
      settle(TGL_GAP);
   endtask

   // First word shifted ends in word 2
   task automatic load_entry(input logic [95:0] e);
      shift_word(e[95:64]);
      shift_word(e[63:32]);
      shift_word(e[31:0]);
   endtask

   // Overflow lasts one cycle and is watched while waiting for done
   task automatic push_entry(output logic ovf_seen);
      logic prev;
      int   n;
      prev     = o_ig_write_done;
      ovf_seen = 1'b0;
      n        = 0;
      @(posedge clk);
      i_ig_wdata_upd <= ~i_ig_wdata_upd;
      pushes++;
      do begin
         @(negedge clk);
         ovf_seen = ovf_seen | o_ig_overflow;
         n++;
      end while (o_ig_write_done == prev && n < DONE_TIMEOUT);
      if (o_ig_write_done == prev) begin
         errors++;
         $display("Timeout at %0d ns: write_done did not toggle after a push", $time);
      end
      check_val("o_ig_write_done", 32'(o_ig_write_done), 32'(pushes[0]));
      settle(4);
   endtask

   task automatic pop_readout();
      logic prev;
      int   n;
      prev = o_eg_read_done;
      n    = 0;
      @(posedge clk);
      i_eg_rdata_upd <= ~i_eg_rdata_upd;
      pops++;
      do begin
         @(negedge clk);
         n++;
      end while (o_eg_read_done == prev && n < DONE_TIMEOUT);
      if (o_eg_read_done == prev) begin
         errors++;
         $display("Timeout at %0d ns: read_done did not toggle after a pop", $time);
      end
      check_val("o_eg_read_done", 32'(o_eg_read_done), 32'(pops[0]));
      settle(4);
   endtask

   task automatic shift_readout();
      @(posedge clk);
      i_eg_rdata_en <= ~i_eg_rdata_en;
      settle(TGL_GAP);
   endtask

   // Readout shows word 0 first
   task automatic read_entry(input logic [95:0] want);
      pop_readout();
      check_val("o_eg_rdata", o_eg_rdata, want[31:0]);
      shift_readout();
      check_val("o_eg_rdata", o_eg_rdata, want[63:32]);
      shift_readout();
      check_val("o_eg_rdata", o_eg_rdata, want[95:64]);
   endtask

   task automatic capture_sample(input logic [31:0] dq0, input logic [31:0] dq1,
                                 input logic [15:0] ca);
      @(posedge clk);
      i_rx_dq0 <= dq0;
      i_rx_dq1 <= dq1;
      i_rx_ca  <= ca;
      i_rx_vld <= 3'b111;
      @(posedge clk);
      i_rx_vld <= 3'b000;
   endtask

   // Every non-zero transmit cycle is matched against the next expected set
   task automatic watch_playback();
      logic [79:0] lanes;
      logic [79:0] want;
      while (!load_done) begin
         @(negedge clk);
         lanes = {o_tx_dq0, o_tx_dq1, o_tx_ca};
         if (lanes != '0) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Unexpected data on the transmit lanes at %0d ns", $time);
            end else begin
               want = exp_q.pop_front();
               check_val("o_tx_dq0", lanes[79:48], want[79:48]);
               check_val("o_tx_dq1", lanes[47:16], want[47:16]);
               check_val("o_tx_ca", 32'(lanes[15:0]), 32'(want[15:0]));
            end
         end
      end
   endtask

   task automatic random_lanes(input int i);
      dq0_v[i] = $random(seed);
      dq1_v[i] = $random(seed);
      r        = $random(seed);
      ca_v[i]  = r[15:0];
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      seed            = 27;
      errors          = 0;
      checks          = 0;
      pushes          = 0;
      pops            = 0;
      load_done       = 1'b0;
      rst             <= 1'b1;
      i_buf_mode      <= 1'b0;
      i_ts_enable     <= 1'b0;
      i_ts_reset      <= 1'b0;
      i_ts_brkpt_en   <= 1'b0;
      i_ts_brkpt_val  <= '0;
      i_ig_wdata_clr  <= 1'b0;
      i_ig_wdata_hold <= 1'b0;
      i_ig_wdata_en   <= 1'b0;
      i_ig_wdata_upd  <= 1'b0;
      i_ig_wdata      <= '0;
      i_eg_rdata_clr  <= 1'b0;
      i_eg_rdata_en   <= 1'b0;
      i_eg_rdata_upd  <= 1'b0;
      i_tx_dq0        <= '0;
      i_tx_dq1        <= '0;
      i_tx_ca         <= '0;
      i_rx_dq0        <= '0;
      i_rx_dq1        <= '0;
      i_rx_ca         <= '0;
      i_rx_vld        <= '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      settle(2);

      // Capture at a breakpoint
      err0 = errors;
      r    = $random(seed);
      bval = 16'd8 + {11'd0, r[4:0]};
      @(posedge clk);
      i_ts_brkpt_val <= bval;
      i_ts_brkpt_en  <= 1'b1;
      i_ts_enable    <= 1'b1;
      settle(int'(bval) + 10);
      for (int i = 0; i < 2; i++) begin
         random_lanes(i);
         capture_sample(dq0_v[i], dq1_v[i], ca_v[i]);
      end
      settle(2);
      for (int i = 0; i < 2; i++) begin
         read_entry(ref_entry(bval, dq0_v[i], dq1_v[i], ca_v[i]));
      end
      end_test("1 capture at breakpoint", err0);

      // Timestamp reset with the breakpoint at 0 holding the count there
      err0 = errors;
      @(posedge clk);
      i_ts_brkpt_val <= '0;
      i_ts_reset     <= 1'b1;
      settle(TGL_GAP);
      @(posedge clk);
      i_ts_reset <= 1'b0;
      settle(TGL_GAP);
      random_lanes(0);
      capture_sample(dq0_v[0], dq1_v[0], ca_v[0]);
      settle(2);
      read_entry(ref_entry(16'd0, dq0_v[0], dq1_v[0], ca_v[0]));
      end_test("2 timestamp reset", err0);

      // Playback of entries stamped with the frozen count
      err0 = errors;
      @(posedge clk);
      i_ts_brkpt_val <= bval;
      i_buf_mode     <= 1'b1;
      settle(int'(bval) + 10);
      for (int i = 0; i < 4; i++) begin
         random_lanes(i);
         dq0_v[i] = dq0_v[i] | 32'h1;
         exp_q.push_back({dq0_v[i], dq1_v[i], ca_v[i]});
      end
      fork
         begin
            for (int i = 0; i < 4; i++) begin
               load_entry(ref_entry(bval, dq0_v[i], dq1_v[i], ca_v[i]));
               push_entry(ovf);
            end
            settle(4);
            load_done = 1'b1;
         end
         watch_playback();
      join
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d played entries never reached the transmit lanes", exp_q.size());
      end
      check_val("o_ig_empty", 32'(o_ig_empty), 32'd1);
      end_test("3 playback", err0);

      // Live mode goes through the output register in one cycle
      err0 = errors;
      @(posedge clk);
      i_buf_mode <= 1'b0;
      settle(TGL_GAP);
      live_cur = '0;
      for (int i = 0; i <= 16; i++) begin
         live_prev = live_cur;
         random_lanes(0);
         live_cur = {dq0_v[0], dq1_v[0], ca_v[0]};
         @(posedge clk);
         i_tx_dq0 <= live_cur[79:48];
         i_tx_dq1 <= live_cur[47:16];
         i_tx_ca  <= live_cur[15:0];
         @(negedge clk);
         if (i > 0) begin
            check_val("o_tx_dq0", o_tx_dq0, live_prev[79:48]);
            check_val("o_tx_dq1", o_tx_dq1, live_prev[47:16]);
            check_val("o_tx_ca", 32'(o_tx_ca), 32'(live_prev[15:0]));
         end
      end
      @(posedge clk);
      i_tx_dq0 <= '0;
      i_tx_dq1 <= '0;
      i_tx_ca  <= '0;
      end_test("4 live mode", err0);

      // Overflow and clear with entries at B+1 that never match
      err0 = errors;
      load_entry(ref_entry(bval + 16'd1, dq0_v[0], dq1_v[0], ca_v[0]));
      for (int i = 0; i < DEPTH; i++) begin
         push_entry(ovf);
      end
      check_val("o_ig_full", 32'(o_ig_full), 32'd1);
      push_entry(ovf);
      check_val("o_ig_overflow", 32'(ovf), 32'd1);
      @(posedge clk);
      i_ig_wdata_clr <= 1'b1;
      @(posedge clk);
      i_ig_wdata_clr <= 1'b0;
      settle(2);
      check_val("o_ig_empty", 32'(o_ig_empty), 32'd1);
      check_val("o_ig_full", 32'(o_ig_full), 32'd0);
      ovf = 1'b0;
      for (int i = 0; i <= DEPTH; i++) begin
         r = $random(seed);
         @(posedge clk);
         i_rx_dq0 <= r;
         i_rx_dq1 <= ~r;
         i_rx_ca  <= r[15:0];
         i_rx_vld <= 3'b001;
         @(negedge clk);
         ovf = ovf | o_eg_overflow;
      end
      @(posedge clk);
      i_rx_vld <= 3'b000;
      settle(1);
      check_val("o_eg_full", 32'(o_eg_full), 32'd1);
      check_val("o_eg_overflow", 32'(ovf), 32'd1);
      @(posedge clk);
      i_eg_rdata_clr <= 1'b1;
      @(posedge clk);
      i_eg_rdata_clr <= 1'b0;
      settle(1);
      check_val("o_eg_empty", 32'(o_eg_empty), 32'd1);
      end_test("5 overflow and clear", err0);

      $display("Tests run: 5, checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, DUT.u_assert.fail_cnt);
      if (errors == 0 && DUT.u_assert.fail_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: ts_counter.sv
`timescale 1ns/1ps

module ts_counter import ucie_buf_pkg::*; (
   input  logic            clk,
   input  logic            rst,
   input  logic            i_enable,
   input  logic            i_clear,
   input  logic            i_brkpt_en,
   input  logic [TS_W-1:0] i_brkpt_val,
   output logic [TS_W-1:0] o_timestamp
);

   logic [TS_W-1:0] count_q;
   logic            brkpt_hit;

   // Freeze point
   assign brkpt_hit = i_brkpt_en && (count_q == i_brkpt_val);

   // Clear wins over enable
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_q <= '0;
      end else if (i_clear) begin
         count_q <= '0;
      end else if (i_enable && !brkpt_hit) begin
         count_q <= count_q + 1'b1;
      end
   end

   assign o_timestamp = count_q;

endmodule

// File: ucie_buf_assert.sv
`timescale 1ns/1ps

module ucie_buf_assert import ucie_buf_pkg::*; #(
   parameter int DEPTH = 32
) (
   input logic                   clk,
   input logic                   rst,
   input logic                   i_ig_full,
   input logic                   i_ig_overflow,
   input logic                   i_eg_full,
   input logic                   i_eg_overflow,
   input logic                   i_ig_clr,
   input logic                   i_eg_clr,
   input logic [$clog2(DEPTH):0] i_ig_rd_ptr,
   input logic [$clog2(DEPTH):0] i_ig_wr_ptr,
   input logic [$clog2(DEPTH):0] i_eg_wr_ptr,
   input logic [DQ_W-1:0]        i_tx_dq0,
   input logic [DQ_W-1:0]        i_tx_dq1,
   input logic [CA_W-1:0]        i_tx_ca
);

   int fail_cnt = 0;

   // Overflow only on a full FIFO, and the write pointer must not move
   ig_ovf_full: assert property (@(posedge clk) disable iff (rst)
      i_ig_overflow && !i_ig_clr |-> i_ig_full ##1 $stable(i_ig_wr_ptr))
      else begin
         $error("ingress overflow while not full or with the entry written");
         fail_cnt++;
      end

   eg_ovf_full: assert property (@(posedge clk) disable iff (rst)
      i_eg_overflow && !i_eg_clr |-> i_eg_full ##1 $stable(i_eg_wr_ptr))
      else begin
         $error("egress overflow while not full or with the entry written");
         fail_cnt++;
      end

   // Read pointer stays put while the ingress FIFO is empty
   ig_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
      (i_ig_rd_ptr == i_ig_wr_ptr) && !i_ig_clr |=> $stable(i_ig_rd_ptr))
      else begin
         $error("ingress FIFO popped while empty");
         fail_cnt++;
      end

   // Lanes still at reset value on the first edge after release
   tx_zero_after_rst: assert property (@(posedge clk)
      $fell(rst) |-> (i_tx_dq0 == '0) && (i_tx_dq1 == '0) && (i_tx_ca == '0))
      else begin
         $error("transmit lanes not zero after reset");
         fail_cnt++;
      end

endmodule

bind ucie_buf_top ucie_buf_assert #(
   .DEPTH (DEPTH)
) u_assert (
   .clk           (clk),
   .rst           (rst),
   .i_ig_full     (o_ig_full),
   .i_ig_overflow (o_ig_overflow),
   .i_eg_full     (o_eg_full),
   .i_eg_overflow (o_eg_overflow),
   .i_ig_clr      (i_ig_wdata_clr),
   .i_eg_clr      (i_eg_rdata_clr),
   .i_ig_rd_ptr   (u_ig.u_fifo.rd_ptr_q),
   .i_ig_wr_ptr   (u_ig.u_fifo.wr_ptr_q),
   .i_eg_wr_ptr   (u_eg.u_fifo.wr_ptr_q),
   .i_tx_dq0      (o_tx_dq0),
   .i_tx_dq1      (o_tx_dq1),
   .i_tx_ca       (o_tx_ca)
);

// File: ucie_buf_pkg.sv
package ucie_buf_pkg;

   // ---------------------------------------------------------------------------
   // Lane and CSR widths
   // ---------------------------------------------------------------------------
   localparam int TS_W        = 16;
   localparam int DQ_W        = 32;
   localparam int CA_W        = 16;
   localparam int CSR_W       = 32;

   // One entry is exactly three CSR words
   localparam int ENTRY_WORDS = 3;

   // ---------------------------------------------------------------------------
   // Entry layout
   // ---------------------------------------------------------------------------

   // Lane view, timestamp in the top bits
   typedef struct packed {
      logic [TS_W-1:0] ts;
      logic [DQ_W-1:0] dq0;
      logic [DQ_W-1:0] dq1;
      logic [CA_W-1:0] ca;
   } entry_fields_t;

   // Same 96 bits seen as CSR words, word 2 holds the timestamp end
   typedef union packed {
      entry_fields_t                     fields;
      logic [ENTRY_WORDS-1:0][CSR_W-1:0] words;
   } entry_u;

endpackage

// File: ucie_buf_top.f
ucie_buf_pkg.sv
fifo_if.sv
csr_sync.sv
ts_counter.sv
entry_fifo.sv
ig_player.sv
eg_capture.sv
ucie_buf_top.sv
ucie_buf_assert.sv
tb_ucie_buf.sv

// File: ucie_buf_top.sv
`timescale 1ns/1ps

module ucie_buf_top import ucie_buf_pkg::*; #(
   parameter int DEPTH = 32
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             i_buf_mode,
   input  logic             i_ts_enable,
   input  logic             i_ts_reset,
   input  logic             i_ts_brkpt_en,
   input  logic [TS_W-1:0]  i_ts_brkpt_val,
   input  logic             i_ig_wdata_clr,
   input  logic             i_ig_wdata_hold,
   input  logic             i_ig_wdata_en,
   input  logic             i_ig_wdata_upd,
   input  logic [CSR_W-1:0] i_ig_wdata,
   input  logic             i_eg_rdata_clr,
   input  logic             i_eg_rdata_en,
   input  logic             i_eg_rdata_upd,
   input  logic [DQ_W-1:0]  i_tx_dq0,
   input  logic [DQ_W-1:0]  i_tx_dq1,
   input  logic [CA_W-1:0]  i_tx_ca,
   input  logic [DQ_W-1:0]  i_rx_dq0,
   input  logic [DQ_W-1:0]  i_rx_dq1,
   input  logic [CA_W-1:0]  i_rx_ca,
   input  logic [2:0]       i_rx_vld,
   output logic             o_ig_empty,
   output logic             o_ig_full,
   output logic             o_ig_overflow,
   output logic             o_ig_write_done,
   output logic [CSR_W-1:0] o_eg_rdata,
   output logic             o_eg_empty,
   output logic             o_eg_full,
   output logic             o_eg_overflow,
   output logic             o_eg_read_done,
   output logic [DQ_W-1:0]  o_tx_dq0,
   output logic [DQ_W-1:0]  o_tx_dq1,
   output logic [CA_W-1:0]  o_tx_ca
);

   logic            buf_mode;
   logic            ts_enable;
   logic            ts_reset;
   logic            ts_brkpt_en;
   logic            ig_shift;
   logic            ig_push;
   logic            eg_shift;
   logic            eg_pop;
   logic [TS_W-1:0] timestamp;

   // CSR controls into the clock domain
   csr_sync u_csr_sync (
      .clk            (clk),
      .rst            (rst),
      .i_buf_mode     (i_buf_mode),
      .i_ts_enable    (i_ts_enable),
      .i_ts_reset     (i_ts_reset),
      .i_ts_brkpt_en  (i_ts_brkpt_en),
      .i_ig_wdata_en  (i_ig_wdata_en),
      .i_ig_wdata_upd (i_ig_wdata_upd),
      .i_eg_rdata_en  (i_eg_rdata_en),
      .i_eg_rdata_upd (i_eg_rdata_upd),
      .o_buf_mode     (buf_mode),
      .o_ts_enable    (ts_enable),
      .o_ts_reset     (ts_reset),
      .o_ts_brkpt_en  (ts_brkpt_en),
      .o_ig_shift     (ig_shift),
      .o_ig_push      (ig_push),
      .o_eg_shift     (eg_shift),
      .o_eg_pop       (eg_pop)
   );

   ts_counter u_ts (
      .clk         (clk),
      .rst         (rst),
      .i_enable    (ts_enable),
      .i_clear     (ts_reset),
      .i_brkpt_en  (ts_brkpt_en),
      .i_brkpt_val (i_ts_brkpt_val),
      .o_timestamp (timestamp)
   );

   // Ingress, CSR to transmit lanes
   ig_player #(
      .DEPTH (DEPTH)
   ) u_ig (
      .clk          (clk),
      .rst          (rst),
      .i_buf_mode   (buf_mode),
      .i_shift      (ig_shift),
      .i_push       (ig_push),
      .i_clr        (i_ig_wdata_clr),
      .i_hold       (i_ig_wdata_hold),
      .i_wdata      (i_ig_wdata),
      .i_timestamp  (timestamp),
      .i_tx_dq0     (i_tx_dq0),
      .i_tx_dq1     (i_tx_dq1),
      .i_tx_ca      (i_tx_ca),
      .o_empty      (o_ig_empty),
      .o_full       (o_ig_full),
      .o_overflow   (o_ig_overflow),
      .o_write_done (o_ig_write_done),
      .o_tx_dq0     (o_tx_dq0),
      .o_tx_dq1     (o_tx_dq1),
      .o_tx_ca      (o_tx_ca)
   );

   // Egress, receive lanes to CSR
   eg_capture #(
      .DEPTH (DEPTH)
   ) u_eg (
      .clk         (clk),
      .rst         (rst),
      .i_shift     (eg_shift),
      .i_pop       (eg_pop),
      .i_clr       (i_eg_rdata_clr),
      .i_timestamp (timestamp),
      .i_rx_dq0    (i_rx_dq0),
      .i_rx_dq1    (i_rx_dq1),
      .i_rx_ca     (i_rx_ca),
      .i_rx_vld    (i_rx_vld),
      .o_rdata     (o_eg_rdata),
      .o_empty     (o_eg_empty),
      .o_full      (o_eg_full),
      .o_overflow  (o_eg_overflow),
      .o_read_done (o_eg_read_done)
   );

endmodule
